// File: rtl/qspi_pkg.sv
// ----------------------------------------
// Types and constants shared by the QSPI flash controller
// Imported by the sequencer, the shifter and the top level
// ----------------------------------------
`default_nettype none

package qspi_pkg;

    localparam int WORD_BITS   = 32;
    localparam int OPCODE_BITS = 8;

    // Active IO lanes of one phase, code 3 unused
    typedef enum logic [1:0] {
        LANES_1 = 2'd0,
        LANES_2 = 2'd1,
        LANES_4 = 2'd2
    } lane_mode_e;

    typedef enum logic [1:0] {
        ADDR_NONE = 2'd0,
        ADDR_3B   = 2'd1,
        ADDR_4B   = 2'd2
    } addr_len_e;

    // Transaction phases, in the order they run
    typedef enum logic [2:0] {
        IDLE, CS_SETUP, CMD, ADDR, DUMMY, DATA, CS_DONE
    } phase_e;

    // Bits moved per SCLK period
    function automatic logic [2:0] lane_count(input lane_mode_e mode);
        case (mode)
            LANES_2: return 3'd2;
            LANES_4: return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/qspi_sclk_gen.sv
// ----------------------------------------
// SCLK divider for SPI modes 0 and 3
// Toggles the pin clock every clk_div+1 cycles while enabled and
// flags the clk cycle before each falling and rising SCLK edge
// ----------------------------------------
`default_nettype none

module qspi_sclk_gen #(
    parameter int DIV_W = 8
) (
    input  wire             clk,
    input  wire             resetn,
    input  wire             sclk_en,
    input  wire [DIV_W-1:0] clk_div,
    input  wire             cpol,
    output wire             sclk,
    output wire             shift_pulse,
    output wire             sample_pulse
);

    logic [DIV_W-1:0] cnt;
    logic             sclk_q;
    logic             primed;
    logic             tick;

    // Edge happens at the end of the tick cycle
    assign tick         = sclk_en && (cnt == clk_div);
    assign sample_pulse = tick && !sclk_q;

    // Mode 3 starts with a falling edge, the first bit is already on the pins
    assign shift_pulse  = tick && sclk_q && primed;
    assign sclk         = sclk_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cnt    <= '0;
            sclk_q <= 1'b0;
            primed <= 1'b0;
        end else if (!sclk_en) begin
            // Park at the idle level
            cnt    <= '0;
            sclk_q <= cpol;
            primed <= 1'b0;
        end else if (tick) begin
            cnt    <= '0;
            sclk_q <= ~sclk_q;
            if (!sclk_q) begin
                primed <= 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    a_pulse_excl: assert property (
        @(posedge clk) disable iff (!resetn) !(shift_pulse && sample_pulse)
    );

endmodule

`default_nettype wire

// File: rtl/qspi_shifter.sv
// ----------------------------------------
// 32-bit MSB-first shift register on the QSPI pins
// Shifts out on shift_pulse, captures on sample_pulse, 1/2/4 lanes
// ----------------------------------------
`default_nettype none

module qspi_shifter (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire                            load,
    input  wire [qspi_pkg::WORD_BITS-1:0]  load_word,
    input  wire                            shift_en,
    input  wire                            capture_en,
    input  qspi_pkg::lane_mode_e           lanes,
    input  wire                            drive,
    input  wire                            shift_pulse,
    input  wire                            sample_pulse,
    output logic [qspi_pkg::WORD_BITS-1:0] word,
    inout  wire                            io0,
    inout  wire                            io1,
    inout  wire                            io2,
    inout  wire                            io3
);

    import qspi_pkg::*;

    logic [3:0] out_bits;
    logic [3:0] in_bits;
    logic [3:0] lane_mask;
    logic [2:0] step;

    assign step = lane_count(lanes);

    // ----------------------------------------
    // Lane muxing
    // ----------------------------------------
    always_comb begin
        case (lanes)
            LANES_2: begin
                out_bits  = {2'b00, word[WORD_BITS-1 -: 2]};
                in_bits   = {2'b00, io1, io0};
                lane_mask = 4'b0011;
            end
            LANES_4: begin
                out_bits  = word[WORD_BITS-1 -: 4];
                in_bits   = {io3, io2, io1, io0};
                lane_mask = 4'b1111;
            end
            default: begin
                // Single lane: SI on io0, SO on io1
                out_bits  = {3'b000, word[WORD_BITS-1]};
                in_bits   = {3'b000, io1};
                lane_mask = 4'b0001;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            word <= '0;
        end else if (load) begin
            word <= load_word;
        end else if (shift_pulse && shift_en) begin
            word <= word << step;
        end else if (sample_pulse && capture_en) begin
            word <= (word << step) | WORD_BITS'(in_bits);
        end
    end

    // Tri-state drivers
    assign io0 = (drive && lane_mask[0]) ? out_bits[0] : 1'bz;
    assign io1 = (drive && lane_mask[1]) ? out_bits[1] : 1'bz;
    assign io2 = (drive && lane_mask[2]) ? out_bits[2] : 1'bz;
    assign io3 = (drive && lane_mask[3]) ? out_bits[3] : 1'bz;

    a_no_drive_on_capture: assert property (
        @(posedge clk) disable iff (!resetn) capture_en |-> !drive
    );

endmodule

`default_nettype wire

// File: rtl/qspi_seq.sv
// ----------------------------------------
// Transaction sequencer of the QSPI controller
// Walks CS setup, command, address, dummy and data phases and
// picks each value loaded into the shifter
// ----------------------------------------
`default_nettype none

module qspi_seq #(
    parameter int LEN_W = 16
) (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              start,
    output wire                              done,
    input  qspi_pkg::lane_mode_e             cmd_lanes,
    input  qspi_pkg::lane_mode_e             addr_lanes,
    input  qspi_pkg::lane_mode_e             data_lanes,
    input  qspi_pkg::addr_len_e              addr_len,
    input  wire [3:0]                        dummy_cycles,
    input  wire                              dir,
    input  wire [qspi_pkg::OPCODE_BITS-1:0]  opcode,
    input  wire [31:0]                       addr,
    input  wire [LEN_W-1:0]                  len_bytes,
    input  wire [qspi_pkg::WORD_BITS-1:0]    tx_data,
    input  wire                              tx_empty,
    output wire                              tx_ren,
    output wire [qspi_pkg::WORD_BITS-1:0]    rx_data,
    output wire                              rx_wen,
    input  wire                              rx_full,
    output logic                             cs_n,
    output wire                              sclk_en,
    input  wire                              shift_pulse,
    input  wire                              sample_pulse,
    output wire                              load,
    output logic [qspi_pkg::WORD_BITS-1:0]   load_word,
    output wire                              shift_en,
    output logic                             capture_en,
    output qspi_pkg::lane_mode_e             lanes,
    output logic                             drive,
    input  wire [qspi_pkg::WORD_BITS-1:0]    word
);

    import qspi_pkg::*;

    phase_e           state;
    phase_e           next_phase;
    logic [5:0]       bit_cnt;
    logic [5:0]       bit_nxt;
    logic [5:0]       addr_bits;
    logic [3:0]       dummy_cnt;
    logic [LEN_W-1:0] byte_cnt;
    logic [LEN_W-1:0] byte_nxt;
    logic             reload;
    logic             word_done;
    logic             word_end;
    logic             phase_end;
    lane_mode_e       cfg_lanes;
    logic             cfg_drive;
    logic             cfg_capture;

    assign bit_nxt   = bit_cnt + {3'b000, lane_count(lanes)};
    assign byte_nxt  = byte_cnt + LEN_W'(4);
    assign addr_bits = (addr_len == ADDR_4B) ? 6'd32 : 6'd24;

    // New values go to the pins on a falling edge, or right away in CS_SETUP
    assign load     = (state == CS_SETUP) || (reload && shift_pulse);
    assign tx_ren   = load && (state == DATA) && !dir && !tx_empty;
    assign shift_en = drive;
    assign sclk_en  = (state == CMD) || (state == ADDR) || (state == DUMMY) || (state == DATA);
    assign done     = (state == CS_DONE);
    assign rx_data  = word;
    assign rx_wen   = word_done && !rx_full;

    // ----------------------------------------
    // Phase end and successor
    // ----------------------------------------
    always_comb begin
        word_end   = (state == DATA) && sample_pulse && (bit_nxt == 6'(WORD_BITS));
        phase_end  = 1'b0;
        next_phase = CS_DONE;
        if (state == CMD || state == ADDR) begin
            if (dummy_cycles != 4'd0) begin
                next_phase = DUMMY;
            end else if (len_bytes != '0) begin
                next_phase = DATA;
            end
        end else if (state == DUMMY && len_bytes != '0) begin
            next_phase = DATA;
        end
        case (state)
            CMD: begin
                phase_end = sample_pulse && (bit_nxt == 6'(OPCODE_BITS));
                if (addr_len != ADDR_NONE) begin
                    next_phase = ADDR;
                end
            end
            ADDR:    phase_end = sample_pulse && (bit_nxt == addr_bits);
            DUMMY:   phase_end = sample_pulse && (4'(dummy_cnt + 4'd1) == dummy_cycles);
            DATA:    phase_end = word_end && (byte_nxt == len_bytes);
            default: phase_end = 1'b0;
        endcase
    end

    // Pin setup taken at each load
    always_comb begin
        cfg_lanes   = data_lanes;
        cfg_drive   = 1'b0;
        cfg_capture = 1'b0;
        load_word   = '0;
        case (state)
            CS_SETUP: begin
                cfg_lanes = cmd_lanes;
                cfg_drive = 1'b1;
                load_word = {opcode, {(WORD_BITS - OPCODE_BITS){1'b0}}};
            end
            ADDR: begin
                cfg_lanes = addr_lanes;
                cfg_drive = 1'b1;
                // 3-byte address goes to the top of the register
                load_word = (addr_len == ADDR_3B) ? {addr[23:0], 8'h00} : addr;
            end
            DATA: begin
                cfg_drive   = !dir;
                cfg_capture = dir;
                if (!dir && !tx_empty) begin
                    load_word = tx_data;
                end
            end
            default: cfg_drive = 1'b0;
        endcase
    end

    // ----------------------------------------
    // State and counters
    // ----------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= IDLE;
            cs_n       <= 1'b1;
            bit_cnt    <= '0;
            dummy_cnt  <= '0;
            byte_cnt   <= '0;
            reload     <= 1'b0;
            word_done  <= 1'b0;
            lanes      <= LANES_1;
            drive      <= 1'b0;
            capture_en <= 1'b0;
        end else begin
            word_done <= word_end && dir;
            if (load) begin
                lanes      <= cfg_lanes;
                drive      <= cfg_drive;
                capture_en <= cfg_capture;
                reload     <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= CS_SETUP;
                        cs_n  <= 1'b0;
                    end
                end
                CS_SETUP: state <= CMD;
                CS_DONE: begin
                    // One clk of CS hold after the last rising SCLK
                    state      <= IDLE;
                    cs_n       <= 1'b1;
                    drive      <= 1'b0;
                    capture_en <= 1'b0;
                end
                default: begin
                    if (phase_end) begin
                        state     <= next_phase;
                        bit_cnt   <= '0;
                        dummy_cnt <= '0;
                        byte_cnt  <= '0;
                        reload    <= (next_phase != CS_DONE);
                    end else if (state == DUMMY && sample_pulse) begin
                        dummy_cnt <= dummy_cnt + 4'd1;
                    end else if (word_end) begin
                        // Next write word goes out on the coming falling edge
                        bit_cnt  <= '0;
                        byte_cnt <= byte_nxt;
                        reload   <= !dir;
                    end else if (sample_pulse) begin
                        bit_cnt <= bit_nxt;
                    end
                end
            endcase
        end
    end

    a_cs_idle: assert property (
        @(posedge clk) disable iff (!resetn) state == IDLE |-> cs_n
    );
    a_rx_no_full: assert property (
        @(posedge clk) disable iff (!resetn) rx_wen |-> !rx_full && $past(capture_en)
    );
    a_start_busy: assert property (
        @(posedge clk) disable iff (!resetn) start && state != IDLE |=> state != CS_SETUP
    );

endmodule

`default_nettype wire

// File: rtl/qspi_ctrl.sv
// ----------------------------------------
// QSPI flash transaction controller, top level
// One start pulse runs one flash transaction; done marks its end
// ----------------------------------------
`default_nettype none

module qspi_ctrl #(
    parameter int DIV_W = 8,
    parameter int LEN_W = 16
) (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             start,
    output wire                             done,
    input  qspi_pkg::lane_mode_e            cmd_lanes,
    input  qspi_pkg::lane_mode_e            addr_lanes,
    input  qspi_pkg::lane_mode_e            data_lanes,
    input  qspi_pkg::addr_len_e             addr_len,
    input  wire [3:0]                       dummy_cycles,
    input  wire                             dir,
    input  wire [qspi_pkg::OPCODE_BITS-1:0] opcode,
    input  wire [31:0]                      addr,
    input  wire [LEN_W-1:0]                 len_bytes,
    input  wire [DIV_W-1:0]                 clk_div,
    input  wire                             cpol,
    input  wire [qspi_pkg::WORD_BITS-1:0]   tx_data,
    input  wire                             tx_empty,
    output wire                             tx_ren,
    output wire [qspi_pkg::WORD_BITS-1:0]   rx_data,
    output wire                             rx_wen,
    input  wire                             rx_full,
    output wire                             sclk,
    output wire                             cs_n,
    inout  wire                             io0,
    inout  wire                             io1,
    inout  wire                             io2,
    inout  wire                             io3
);

    import qspi_pkg::*;

    wire                 sclk_en;
    wire                 shift_pulse;
    wire                 sample_pulse;
    wire                 load;
    wire [WORD_BITS-1:0] load_word;
    wire                 shift_en;
    wire                 capture_en;
    lane_mode_e          lanes;
    wire                 drive;
    wire [WORD_BITS-1:0] word;

    qspi_seq #(
        .LEN_W(LEN_W)
    ) u_seq (
        .clk(clk), .resetn(resetn), .start(start), .done(done),
        .cmd_lanes(cmd_lanes), .addr_lanes(addr_lanes), .data_lanes(data_lanes),
        .addr_len(addr_len), .dummy_cycles(dummy_cycles), .dir(dir),
        .opcode(opcode), .addr(addr), .len_bytes(len_bytes),
        .tx_data(tx_data), .tx_empty(tx_empty), .tx_ren(tx_ren),
        .rx_data(rx_data), .rx_wen(rx_wen), .rx_full(rx_full),
        .cs_n(cs_n), .sclk_en(sclk_en),
        .shift_pulse(shift_pulse), .sample_pulse(sample_pulse),
        .load(load), .load_word(load_word), .shift_en(shift_en),
        .capture_en(capture_en), .lanes(lanes), .drive(drive), .word(word)
    );

    qspi_sclk_gen #(
        .DIV_W(DIV_W)
    ) u_sclk_gen (
        .clk(clk), .resetn(resetn), .sclk_en(sclk_en), .clk_div(clk_div),
        .cpol(cpol), .sclk(sclk),
        .shift_pulse(shift_pulse), .sample_pulse(sample_pulse)
    );

    qspi_shifter u_shifter (
        .clk(clk), .resetn(resetn), .load(load), .load_word(load_word),
        .shift_en(shift_en), .capture_en(capture_en), .lanes(lanes), .drive(drive),
        .shift_pulse(shift_pulse), .sample_pulse(sample_pulse), .word(word),
        .io0(io0), .io1(io1), .io2(io2), .io3(io3)
    );

endmodule

`default_nettype wire

// File: verif/qspi_flash_model.sv
// ----------------------------------------
// Behavioral serial flash for the QSPI testbench
// Decodes command, address and write words on rising SCLK
// Drives read words on falling SCLK
// Read word k holds C0DE in the upper half and k in the lower half
// ----------------------------------------
`default_nettype none

module qspi_flash_model (
    input  wire        sclk,
    input  wire        cs_n,
    inout  wire        io0,
    inout  wire        io1,
    inout  wire        io2,
    inout  wire        io3,
    input  wire [2:0]  cmd_n,
    input  wire [2:0]  addr_n,
    input  wire [2:0]  data_n,
    input  wire [2:0]  addr_bytes,
    input  wire [3:0]  dummy,
    input  wire [15:0] len,
    input  wire        dir,
    output logic [7:0] opcode,
    output logic [31:0] addr,
    output int         edges,
    output int         wr_count
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] wr_words [0:15];
    logic [31:0] shreg;
    logic [3:0]  oe;
    logic [3:0]  dout;
    int          e_cmd;
    int          e_addr;
    int          pre;
    int          total;
    int          epw;

    // Edge boundaries of each phase
    always_comb begin
        e_cmd  = 8 / cmd_n;
        e_addr = (addr_bytes * 8) / addr_n;
        pre    = e_cmd + e_addr + dummy;
        epw    = 32 / data_n;
        total  = pre + (8 * len) / data_n;
    end

    assign io0 = oe[0] ? dout[0] : 1'bz;
    assign io1 = oe[1] ? dout[1] : 1'bz;
    assign io2 = oe[2] ? dout[2] : 1'bz;
    assign io3 = oe[3] ? dout[3] : 1'bz;

    initial begin
        oe       = 4'b0000;
        dout     = 4'b0000;
        edges    = 0;
        wr_count = 0;
    end

    always @(negedge cs_n) begin
        edges    = 0;
        wr_count = 0;
        opcode   = '0;
        addr     = '0;
        shreg    = '0;
    end

    always @(posedge cs_n) begin
        oe = 4'b0000;
    end

    // ----------------------------------------
    // Capture on rising SCLK
    // ----------------------------------------
    always @(posedge sclk) begin
        int         n;
        logic [3:0] b;
        if (!cs_n) begin
            if (edges < e_cmd) begin
                n = cmd_n;
            end else if (edges < e_cmd + e_addr) begin
                n = addr_n;
            end else begin
                n = data_n;
            end
            b = (n == 4) ? {io3, io2, io1, io0} : (n == 2) ? {2'b00, io1, io0} : {3'b000, io0};
            if (edges < e_cmd) begin
                opcode = (opcode << n) | 8'(b);
            end else if (edges < e_cmd + e_addr) begin
                addr = (addr << n) | 32'(b);
            end else if (edges >= pre && edges < total && !dir) begin
                shreg = (shreg << n) | 32'(b);
                if ((edges - pre + 1) % epw == 0) begin
                    wr_words[wr_count] = shreg;
                    wr_count++;
                end
            end
            edges++;
        end
    end

    // Read data changes on falling SCLK
    always @(negedge sclk) begin
        int          d;
        int          k;
        int          j;
        logic [31:0] w;
        logic [31:0] v;
        if (!cs_n && dir && edges >= pre && edges < total) begin
            d = edges - pre;
            k = d / epw;
            j = d % epw;
            w = {16'hC0DE, 16'(k)};
            v = w >> (32 - data_n * (j + 1));
            if (data_n == 4) begin
                oe   = 4'b1111;
                dout = v[3:0];
            end else if (data_n == 2) begin
                oe   = 4'b0011;
                dout = {2'b00, v[1:0]};
            end else begin
                // Single lane answers on io1
                oe   = 4'b0010;
                dout = {2'b00, v[0], 1'b0};
            end
        end else begin
            oe = 4'b0000;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_qspi_ctrl.sv
// ----------------------------------------
// Testbench for the QSPI flash controller
// Runs a table of flash transactions against a behavioral flash,
// with TX and RX FIFO models around the DUT
// ----------------------------------------
`default_nettype none

module tb_qspi_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    import qspi_pkg::*;

    localparam int NUM_ROWS = 7;

    typedef struct {
        int          nc;
        int          na;
        int          nd;
        int          abytes;
        int          dummy;
        logic        dir;
        logic [7:0]  op;
        logic [31:0] adr;
        int          len;
        int          div;
        logic        cpol;
        logic [3:0]  drop;
    } row_t;

    row_t        rows [NUM_ROWS];
    logic        clk;
    logic        resetn;
    logic        start;
    wire         done;
    lane_mode_e  cmd_lanes;
    lane_mode_e  addr_lanes;
    lane_mode_e  data_lanes;
    addr_len_e   addr_len;
    logic [3:0]  dummy_cycles;
    logic        dir;
    logic [7:0]  opcode;
    logic [31:0] addr;
    logic [15:0] len_bytes;
    logic [7:0]  clk_div;
    logic        cpol;
    logic [31:0] tx_data;
    logic        tx_empty;
    wire         tx_ren;
    wire  [31:0] rx_data;
    wire         rx_wen;
    logic        rx_full;
    wire         sclk;
    wire         cs_n;
    wire         io0;
    wire         io1;
    wire         io2;
    wire         io3;

    // Flash model configuration
    logic [2:0]  m_nc;
    logic [2:0]  m_na;
    logic [2:0]  m_nd;
    logic [2:0]  m_abytes;
    logic [3:0]  m_dummy;
    logic [15:0] m_len;
    logic        m_dir;
    wire  [7:0]  m_opcode;
    wire  [31:0] m_addr;
    int          m_edges;
    int          m_wr_count;

    logic [31:0] tx_mem [0:15];
    logic [31:0] rx_got [0:15];
    int          tx_rd;
    int          tx_wr;
    int          tx_pulses;
    int          rx_n;
    int          cur_pre;
    int          cur_epw;
    logic [3:0]  cur_drop;
    logic        cur_dir;
    int          errors;
    int          failed;
    int          cycles;
    int          limit;
    int          seed;

    qspi_ctrl #(.DIV_W(8), .LEN_W(16)) u_dut (
        .clk(clk), .resetn(resetn), .start(start), .done(done),
        .cmd_lanes(cmd_lanes), .addr_lanes(addr_lanes), .data_lanes(data_lanes),
        .addr_len(addr_len), .dummy_cycles(dummy_cycles), .dir(dir),
        .opcode(opcode), .addr(addr), .len_bytes(len_bytes),
        .clk_div(clk_div), .cpol(cpol),
        .tx_data(tx_data), .tx_empty(tx_empty), .tx_ren(tx_ren),
        .rx_data(rx_data), .rx_wen(rx_wen), .rx_full(rx_full),
        .sclk(sclk), .cs_n(cs_n), .io0(io0), .io1(io1), .io2(io2), .io3(io3)
    );

    qspi_flash_model u_flash (
        .sclk(sclk), .cs_n(cs_n), .io0(io0), .io1(io1), .io2(io2), .io3(io3),
        .cmd_n(m_nc), .addr_n(m_na), .data_n(m_nd), .addr_bytes(m_abytes),
        .dummy(m_dummy), .len(m_len), .dir(m_dir),
        .opcode(m_opcode), .addr(m_addr), .edges(m_edges), .wr_count(m_wr_count)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // FIFO models and watchdog
    // ----------------------------------------
    always @(posedge clk) begin
        if (tx_ren) begin
            tx_rd = tx_rd + 1;
            tx_pulses++;
        end
        tx_data  <= tx_mem[tx_rd];
        tx_empty <= (tx_rd >= tx_wr);
    end

    always @(posedge clk) begin
        if (rx_wen) begin
            rx_got[rx_n] = rx_data;
            rx_n++;
        end
    end

    // Full flag follows the word index, switched mid-word so it is steady at word end
    always @(posedge clk) begin
        int m;
        if (cur_dir && m_edges > cur_pre) begin
            m = (m_edges - cur_pre + cur_epw / 2) / cur_epw;
            rx_full <= (m > 0 && m <= 4) ? cur_drop[m-1] : 1'b0;
        end else begin
            rx_full <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: no end of run after %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic lane_mode_e mode_of(input int n);
        return (n == 4) ? LANES_4 : (n == 2) ? LANES_2 : LANES_1;
    endfunction

    function automatic int periods_of(input row_t r);
        return 8 / r.nc + (r.abytes * 8) / r.na + r.dummy + (8 * r.len) / r.nd;
    endfunction

    task automatic add_row(input int i, input int nc, input int na, input int nd,
                           input int abytes, input int dmy, input logic rd,
                           input logic [7:0] op, input logic [31:0] adr, input int len,
                           input int div, input logic pol, input logic [3:0] drop);
        rows[i] = '{nc, na, nd, abytes, dmy, rd, op, adr, len, div, pol, drop};
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
        assert (got === exp) else begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int i);
        int          n_words;
        int          n_exp;
        int          e0;
        int          k;
        row_t        r;
        r       = rows[i];
        e0      = errors;
        n_words = r.len / 4;
        @(posedge clk);
        cmd_lanes    <= mode_of(r.nc);
        addr_lanes   <= mode_of(r.na);
        data_lanes   <= mode_of(r.nd);
        addr_len     <= (r.abytes == 0) ? ADDR_NONE : (r.abytes == 3) ? ADDR_3B : ADDR_4B;
        dummy_cycles <= 4'(r.dummy);
        dir          <= r.dir;
        opcode       <= r.op;
        addr         <= r.adr;
        len_bytes    <= 16'(r.len);
        clk_div      <= 8'(r.div);
        cpol         <= r.cpol;
        m_nc         <= 3'(r.nc);
        m_na         <= 3'(r.na);
        m_nd         <= 3'(r.nd);
        m_abytes     <= 3'(r.abytes);
        m_dummy      <= 4'(r.dummy);
        m_len        <= 16'(r.len);
        m_dir        <= r.dir;
        cur_pre   = 8 / r.nc + (r.abytes * 8) / r.na + r.dummy;
        cur_epw   = 32 / r.nd;
        cur_drop  = r.drop;
        cur_dir   = r.dir;
        tx_rd     = 0;
        tx_pulses = 0;
        rx_n      = 0;
        tx_wr     = r.dir ? 0 : n_words;
        for (k = 0; k < n_words; k++) begin
            tx_mem[k] = $random(seed);
        end
        repeat (3) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(posedge clk); while (done !== 1'b1);
        repeat (3) @(posedge clk);

        compare(32'(m_opcode), 32'(r.op), "opcode");
        if (r.abytes == 3) begin
            compare(m_addr, {8'h00, r.adr[23:0]}, "address");
        end else if (r.abytes == 4) begin
            compare(m_addr, r.adr, "address");
        end
        compare(32'(m_edges), 32'(periods_of(r)), "SCLK rising edges");
        compare(32'(cs_n), 32'd1, "cs_n after done");
        compare(32'(sclk), 32'(r.cpol), "sclk idle level");
        if (!r.dir) begin
            compare(32'(tx_pulses), 32'(n_words), "tx_ren pulses");
            compare(32'(m_wr_count), 32'(n_words), "write words seen");
            for (k = 0; k < n_words && k < m_wr_count; k++) begin
                compare(u_flash.wr_words[k], tx_mem[k], $sformatf("write word %0d", k));
            end
        end else begin
            n_exp = 0;
            for (k = 0; k < n_words; k++) begin
                if (!(k < 4 && r.drop[k])) begin
                    if (n_exp < rx_n) begin
                        compare(rx_got[n_exp], {16'hC0DE, 16'(k)}, $sformatf("read word %0d", k));
                    end
                    n_exp++;
                end
            end
            compare(32'(rx_n), 32'(n_exp), "rx_wen pulses");
        end
        if (errors != e0) begin
            failed++;
        end
        $display("Test %0d %s: %s (%0d errors)", i, r.dir ? "read" : "write",
                 (errors == e0) ? "ok" : "FAIL", errors - e0);
    endtask

    initial begin
        int i;
        seed = 57;
        clk = 1'b0;
        resetn = 1'b0;
        start = 1'b0;
        cmd_lanes = LANES_1;
        addr_lanes = LANES_1;
        data_lanes = LANES_1;
        addr_len = ADDR_NONE;
        dummy_cycles = 4'd0;
        dir = 1'b0;
        opcode = 8'h00;
        addr = 32'h0;
        len_bytes = 16'd0;
        clk_div = 8'd0;
        cpol = 1'b0;
        tx_data = 32'h0;
        tx_empty = 1'b1;
        rx_full = 1'b0;
        {m_nc, m_na, m_nd} = {3'd1, 3'd1, 3'd1};
        m_abytes = 3'd0;
        m_dummy = 4'd0;
        m_len = 16'd0;
        m_dir = 1'b0;
        tx_rd = 0;
        tx_wr = 0;
        rx_n = 0;
        cur_pre = 0;
        cur_epw = 32;
        cur_drop = 4'b0000;
        cur_dir = 1'b0;
        errors = 0;
        failed = 0;
        cycles = 0;

        //      i  nc na nd ab dm rd  op     adr           len div cpol drop
        add_row(0, 1, 1, 1, 3, 0, 0, 8'h02, 32'h0012_3456, 8, 1, 0, 4'b0000);
        add_row(1, 1, 1, 4, 3, 0, 0, 8'h32, 32'h00AB_CDEF, 12, 0, 1, 4'b0000);
        add_row(2, 1, 4, 4, 4, 0, 0, 8'h3E, 32'h1234_5678, 8, 2, 0, 4'b0000);
        add_row(3, 1, 2, 2, 3, 4, 1, 8'hBB, 32'h0045_6780, 8, 1, 1, 4'b0000);
        add_row(4, 1, 4, 4, 4, 6, 1, 8'hEC, 32'hDEAD_0100, 16, 0, 0, 4'b0100);
        add_row(5, 4, 4, 4, 3, 2, 1, 8'hEB, 32'h0001_2340, 12, 3, 1, 4'b0001);
        add_row(6, 2, 1, 1, 0, 0, 0, 8'h06, 32'h0, 0, 1, 0, 4'b0000);

        limit = 0;
        for (i = 0; i < NUM_ROWS; i++) begin
            limit += periods_of(rows[i]) * 2 * (rows[i].div + 1) + 100;
        end

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        for (i = 0; i < NUM_ROWS; i++) begin
            run_test(i);
        end
        $display("Tests: %0d, failed: %0d, errors: %0d", NUM_ROWS, failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: qspi_ctrl.f
rtl/qspi_pkg.sv
rtl/qspi_sclk_gen.sv
rtl/qspi_shifter.sv
rtl/qspi_seq.sv
rtl/qspi_ctrl.sv
verif/qspi_flash_model.sv
verif/tb_qspi_ctrl.sv
